//--- filelist.f
source/xosera_pkg.sv
source/xosera_if.sv
source/bus_reg_ctrl.sv
source/video_timing.sv
source/vram.sv
source/pixel_fetch.sv
source/audio_pwm.sv
source/xosera_top.sv
testbench/tb_xosera.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_xosera
FILELIST = filelist.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- testbench/tb_xosera.sv
// ##################################################
// self-checking testbench for the video/audio controller
// stops at the first mismatch or timeout
// VRAM content comes from an LCG, shadowed for checks
// ##################################################

module tb_xosera;
    timeunit 1ns;
    timeprecision 1ps;
    import xosera_pkg::*;

    logic       pclk = 1'b0;
    logic       rst_n_i;
    logic       bus_cs_n_i;
    logic       bus_rd_nwr_i;
    logic       bus_bytesel_i;
    logic [3:0] bus_reg_num_i;
    logic [7:0] bus_data_i;
    logic [7:0] bus_data_o;
    logic       bus_oe_o;
    logic [3:0] red_o;
    logic [3:0] green_o;
    logic [3:0] blue_o;
    logic       hsync_o;
    logic       vsync_o;
    logic       de_o;
    logic       audio_l_o;
    logic       audio_r_o;

    logic [15:0] shadow [VRAM_WORDS];             // reference VRAM copy
    logic [31:0] rng;                             // LCG state
    logic        scan_en;                         // frame compare running
    logic        scan_done;
    int          scan_cnt;
    int          row;                             // counted by de rising edges
    int          col;                             // pixel within the active line
    int          hpos;                            // pixel within the line, -1 until de rises
    logic        prev_de;

    xosera_top i_dut (.*);

    always #10 pclk = ~pclk;                      // 20 ns period

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // visible pixel is the low 12 bits of its word, red on top
    function automatic logic [11:0] expected_rgb(input int r, input int c);
        return shadow[r * H_ACTIVE + c][11:0];
    endfunction

    // sync pulse follows the front porch after the active pixels
    function automatic logic in_hsync_window(input int h);
        return (h >= H_ACTIVE + H_FRONT) && (h < H_ACTIVE + H_FRONT + H_SYNC);
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (exp === act) else begin
            $display("FAIL %s: expected %0h, actual %0h", name, exp, act);
            $display("TEST RESULT: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timeout while waiting for %s", what);
        $display("TEST RESULT: FAIL");
        $fatal(1, "timeout");
    endtask

    // one sampled access, cs low for a single edge
    task automatic drive_access(input logic rd, input logic bsel, input logic [3:0] num,
                                input logic [7:0] din, output logic [7:0] dout);
        @(posedge pclk);
        bus_cs_n_i    <= 1'b0;
        bus_rd_nwr_i  <= rd;
        bus_bytesel_i <= bsel;
        bus_reg_num_i <= num;
        bus_data_i    <= din;
        @(posedge pclk);                          // DUT samples here
        bus_cs_n_i    <= 1'b1;
        @(negedge pclk);
        dout = bus_data_o;                        // loaded at the sampling edge
        if (rd)
            check_value("bus_oe after read", 1, bus_oe_o);
        repeat (4) @(posedge pclk);               // idle gap for write/prefetch
    endtask

    task automatic bus_write(input logic [3:0] num, input logic [15:0] word);
        logic [7:0] unused;
        drive_access(1'b0, 1'b0, num, word[15:8], unused);   // even byte latched
        drive_access(1'b0, 1'b1, num, word[7:0], unused);    // odd byte commits
    endtask

    task automatic bus_read(input logic [3:0] num, output logic [15:0] word);
        logic [7:0] hi;
        logic [7:0] lo;
        drive_access(1'b1, 1'b0, num, 8'h00, hi);
        drive_access(1'b1, 1'b1, num, 8'h00, lo);
        word = {hi, lo};
    endtask

    task automatic readback_all();
        logic [15:0] w;
        bus_write(REG_RD_ADDR, 16'h0000);
        for (int i = 0; i < VRAM_WORDS; i++) begin
            bus_read(REG_RD_DATA, w);             // odd byte bumps read addr
            check_value("vram readback", shadow[i], w);
        end
    endtask

    task automatic wait_vsync_rise();
        int   n;
        logic prev;
        logic found;
        n     = 0;
        prev  = 1'b1;                             // needs a fresh low to high
        found = 1'b0;
        while (!found && n < 2 * H_TOTAL * V_TOTAL) begin
            @(negedge pclk);
            found = vsync_o && !prev;
            prev  = vsync_o;
            n++;
        end
        if (!found)
            report_timeout("rising vsync");
    endtask

    task automatic count_high(output int cnt_l, output int cnt_r);
        cnt_l = 0;
        cnt_r = 0;
        for (int i = 0; i < 256; i++) begin       // one full PWM period
            @(negedge pclk);
            cnt_l += int'(audio_l_o);
            cnt_r += int'(audio_r_o);
        end
    endtask

    // frame comparator, runs on falling edges while enabled
    always @(negedge pclk) begin
        if (scan_en) begin
            if (de_o && !prev_de)
                hpos = 0;                         // de rise marks pixel 0
            else if (hpos >= 0)
                hpos = (hpos + 1) % H_TOTAL;
            if (hpos >= 0)
                check_value("hsync", in_hsync_window(hpos), hsync_o);
            if (de_o) begin
                if (!prev_de) begin
                    row = row + 1;                // new visible line
                    col = 0;
                end
                check_value("frame rgb", expected_rgb(row, col), {red_o, green_o, blue_o});
                col = col + 1;
            end else begin
                if (prev_de)
                    check_value("pixels per line", H_ACTIVE, col);
                check_value("blank rgb", 0, {red_o, green_o, blue_o});
            end
            prev_de  = de_o;
            scan_cnt = scan_cnt + 1;
            if (scan_cnt == H_TOTAL * V_TOTAL) begin
                scan_en   = 1'b0;
                scan_done = 1'b1;
            end
        end
    end

    initial begin
        int          n;
        int          hi_l;
        int          hi_r;
        logic [15:0] w;
        logic [6:0]  addr;
        logic [7:0]  lvl_l;
        logic [7:0]  lvl_r;

        rng           = 32'h720f;
        scan_en       = 1'b0;
        scan_done     = 1'b0;
        rst_n_i       = 1'b0;
        bus_cs_n_i    = 1'b1;
        bus_rd_nwr_i  = 1'b1;
        bus_bytesel_i = 1'b0;
        bus_reg_num_i = 4'h0;
        bus_data_i    = 8'h00;
        repeat (4) @(posedge pclk);
        rst_n_i <= 1'b1;

        @(negedge pclk);                          // state straight after reset
        check_value("oe after reset", 0, bus_oe_o);
        check_value("data after reset", 0, bus_data_o);
        check_value("de after reset", 0, de_o);
        check_value("rgb after reset", 0, {red_o, green_o, blue_o});
        check_value("sync after reset", 0, {hsync_o, vsync_o});
        check_value("audio after reset", 0, {audio_l_o, audio_r_o});

        bus_write(REG_WR_ADDR, 16'h0000);         // fill VRAM with random words
        for (int i = 0; i < VRAM_WORDS; i++) begin
            rng       = lcg_step(rng);
            shadow[i] = rng[31:16];
            bus_write(REG_DATA, shadow[i]);
        end
        readback_all();

        rng  = lcg_step(rng);                     // random read address
        addr = rng[22:16];
        bus_write(REG_RD_ADDR, {9'b0, addr});
        bus_read(REG_RD_DATA, w);
        check_value("random addr word", shadow[addr], w);
        bus_read(REG_RD_DATA, w);
        check_value("next addr word", shadow[7'(addr + 7'd1)], w);

        wait_vsync_rise();                        // one frame scan
        @(posedge pclk);
        row      = -1;
        col      = 0;
        hpos     = -1;
        prev_de  = 1'b0;
        scan_cnt = 0;
        scan_en  = 1'b1;
        n        = 0;
        while (!scan_done && n < 2 * H_TOTAL * V_TOTAL) begin
            @(posedge pclk);
            n++;
        end
        if (!scan_done)
            report_timeout("end of frame scan");
        check_value("active lines", V_ACTIVE, row + 1);

        rng   = lcg_step(rng);                    // audio levels
        lvl_l = rng[31:24];
        lvl_r = rng[23:16];
        bus_write(REG_AUDIO, {lvl_l, lvl_r});
        repeat (512) @(posedge pclk);             // past at least one wrap
        count_high(hi_l, hi_r);
        check_value("audio left duty", lvl_l, hi_l);
        check_value("audio right duty", lvl_r, hi_r);
        bus_read(REG_AUDIO, w);
        check_value("audio readback", {lvl_l, lvl_r}, w);

        rng = lcg_step(rng);                      // unused register number
        bus_write(4'd9, rng[31:16]);
        bus_read(4'd9, w);
        check_value("unused reg read", 0, w);
        bus_read(REG_WR_ADDR, w);
        check_value("write addr wrapped", 0, w);
        readback_all();

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

//--- source/xosera_top.sv
// ##################################################
// top level, data bus split into in, out and enable
// external asynchronous reset, no PLL
// ##################################################

module xosera_top (
    input  logic       pclk,
    input  logic       rst_n_i,
    input  logic       bus_cs_n_i,
    input  logic       bus_rd_nwr_i,
    input  logic       bus_bytesel_i,
    input  logic [3:0] bus_reg_num_i,
    input  logic [7:0] bus_data_i,
    output logic [7:0] bus_data_o,
    output logic       bus_oe_o,
    output logic [3:0] red_o,
    output logic [3:0] green_o,
    output logic [3:0] blue_o,
    output logic       hsync_o,
    output logic       vsync_o,
    output logic       de_o,
    output logic       audio_l_o,
    output logic       audio_r_o
);
    import xosera_pkg::*;

    logic [VRAM_AW-1:0] a_addr;                   // host side VRAM port
    logic               a_we;
    logic [15:0]        a_wdata;
    logic [15:0]        a_rdata;
    logic [VRAM_AW-1:0] b_addr;                   // display side VRAM port
    logic [15:0]        b_rdata;
    logic [AUDIO_W-1:0] level_l;
    logic [AUDIO_W-1:0] level_r;

    host_bus_if bus ();
    vid_if      vid ();

    assign bus.cs_n    = bus_cs_n_i;
    assign bus.rd_nwr  = bus_rd_nwr_i;
    assign bus.bytesel = bus_bytesel_i;
    assign bus.reg_num = bus_reg_num_i;
    assign bus.data_in = bus_data_i;
    assign bus_data_o  = bus.data_out;
    assign bus_oe_o    = bus.out_ena;

    bus_reg_ctrl i_ctrl (
        .pclk(pclk), .rst_n_i(rst_n_i), .bus(bus),
        .vram_addr_o(a_addr), .vram_we_o(a_we), .vram_wdata_o(a_wdata),
        .vram_rdata_i(a_rdata), .audio_l_o(level_l), .audio_r_o(level_r)
    );

    video_timing i_timing (.pclk(pclk), .rst_n_i(rst_n_i), .vid(vid));

    vram i_vram (
        .pclk(pclk), .a_addr_i(a_addr), .a_we_i(a_we), .a_wdata_i(a_wdata),
        .a_rdata_o(a_rdata), .b_addr_i(b_addr), .b_rdata_o(b_rdata)
    );

    pixel_fetch i_fetch (
        .pclk(pclk), .rst_n_i(rst_n_i), .vid(vid),
        .vram_addr_o(b_addr), .vram_rdata_i(b_rdata),
        .red_o(red_o), .green_o(green_o), .blue_o(blue_o),
        .hsync_o(hsync_o), .vsync_o(vsync_o), .de_o(de_o)
    );

    audio_pwm i_audio (
        .pclk(pclk), .rst_n_i(rst_n_i), .level_l_i(level_l), .level_r_i(level_r),
        .audio_l_o(audio_l_o), .audio_r_o(audio_r_o)
    );

endmodule

//--- source/audio_pwm.sv
// ##################################################
// two channel PWM, period is 2**AUDIO_W cycles
// levels are taken at counter wrap only
// level 0 is silent, full scale is one cycle short
// ##################################################

module audio_pwm (
    input  logic                           pclk,
    input  logic                           rst_n_i,
    input  logic [xosera_pkg::AUDIO_W-1:0] level_l_i,
    input  logic [xosera_pkg::AUDIO_W-1:0] level_r_i,
    output logic                           audio_l_o,
    output logic                           audio_r_o
);
    import xosera_pkg::*;

    logic [AUDIO_W-1:0] pwm_cnt;                  // shared free-running count
    logic [AUDIO_W-1:0] lvl_l;                    // level for this period
    logic [AUDIO_W-1:0] lvl_r;

    always_ff @(posedge pclk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pwm_cnt   <= '0;
            lvl_l     <= '0;
            lvl_r     <= '0;
            audio_l_o <= 1'b0;
            audio_r_o <= 1'b0;
        end else begin
            pwm_cnt <= pwm_cnt + 1'b1;
            if (&pwm_cnt) begin                   // wrap, new period
                lvl_l <= level_l_i;
                lvl_r <= level_r_i;
            end
            audio_l_o <= (pwm_cnt < lvl_l);
            audio_r_o <= (pwm_cnt < lvl_r);
        end
    end

endmodule

//--- source/pixel_fetch.sv
// ##################################################
// display side VRAM read and colour output
// sync and enable are delayed 1 cycle to meet the data
// colour is forced to zero outside the visible area
// ##################################################

module pixel_fetch (
    input  logic                           pclk,
    input  logic                           rst_n_i,
    vid_if.sink                            vid,
    output logic [xosera_pkg::VRAM_AW-1:0] vram_addr_o,
    input  logic [15:0]                    vram_rdata_i,
    output logic [3:0]                     red_o,
    output logic [3:0]                     green_o,
    output logic [3:0]                     blue_o,
    output logic                           hsync_o,
    output logic                           vsync_o,
    output logic                           de_o
);
    import xosera_pkg::*;

    // row * H_ACTIVE + col, junk in blanking but never shown
    assign vram_addr_o = VRAM_AW'(vid.v_count * H_ACTIVE + vid.h_count);

    always_ff @(posedge pclk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            hsync_o <= 1'b0;
            vsync_o <= 1'b0;
            de_o    <= 1'b0;
        end else begin
            hsync_o <= vid.hsync;                 // same lag as VRAM read
            vsync_o <= vid.vsync;
            de_o    <= vid.de;
        end
    end

    assign {red_o, green_o, blue_o} = de_o ? vram_rdata_i[11:0] : 12'h000;

endmodule

//--- source/vram.sv
// ##################################################
// dual port word memory, 1 cycle read latency
// no reset, contents are unknown until written
// port A reads old data on a same-address write
// ##################################################

module vram (
    input  logic                           pclk,
    input  logic [xosera_pkg::VRAM_AW-1:0] a_addr_i,
    input  logic                           a_we_i,
    input  logic [15:0]                    a_wdata_i,
    output logic [15:0]                    a_rdata_o,
    input  logic [xosera_pkg::VRAM_AW-1:0] b_addr_i,
    output logic [15:0]                    b_rdata_o
);
    import xosera_pkg::*;

    logic [15:0] mem [VRAM_WORDS];

    always_ff @(posedge pclk) begin               // host port
        if (a_we_i)
            mem[a_addr_i] <= a_wdata_i;
        a_rdata_o <= mem[a_addr_i];
    end

    always_ff @(posedge pclk) begin               // display port
        b_rdata_o <= mem[b_addr_i];
    end

endmodule

//--- source/video_timing.sv
// ##################################################
// pixel and line counters with sync and enable decode
// outputs are decoded from the counts, not registered
// frame starts in vertical blanking after reset
// ##################################################

module video_timing (
    input  logic pclk,
    input  logic rst_n_i,
    vid_if.source vid
);
    import xosera_pkg::*;

    logic h_last;                                 // last pixel of line
    logic v_last;                                 // last line of frame

    assign h_last = (vid.h_count == H_CW'(H_TOTAL - 1));
    assign v_last = (vid.v_count == V_CW'(V_TOTAL - 1));

    always_ff @(posedge pclk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            vid.h_count <= '0;
            vid.v_count <= V_CW'(V_ACTIVE);       // start in front porch
        end else begin
            if (h_last) begin
                vid.h_count <= '0;
                if (v_last)
                    vid.v_count <= '0;
                else
                    vid.v_count <= vid.v_count + 1'b1;
            end else begin
                vid.h_count <= vid.h_count + 1'b1;
            end
        end
    end

    assign vid.de    = (vid.h_count < H_ACTIVE) && (vid.v_count < V_ACTIVE);
    assign vid.hsync = (vid.h_count >= H_ACTIVE + H_FRONT) &&
                       (vid.h_count <  H_ACTIVE + H_FRONT + H_SYNC);
    assign vid.vsync = (vid.v_count >= V_ACTIVE + V_FRONT) &&
                       (vid.v_count <  V_ACTIVE + V_FRONT + V_SYNC);

endmodule

//--- source/bus_reg_ctrl.sv
// ##################################################
// register decode for the 8-bit host bus
// host must leave 3+ idle cycles between accesses
// so a write or prefetch finishes before the next one
// addresses wrap at VRAM_WORDS
// ##################################################

module bus_reg_ctrl (
    input  logic                              pclk,
    input  logic                              rst_n_i,
    host_bus_if.ctrl                          bus,
    output logic [xosera_pkg::VRAM_AW-1:0]    vram_addr_o,
    output logic                              vram_we_o,
    output logic [15:0]                       vram_wdata_o,
    input  logic [15:0]                       vram_rdata_i,
    output logic [xosera_pkg::AUDIO_W-1:0]    audio_l_o,
    output logic [xosera_pkg::AUDIO_W-1:0]    audio_r_o
);
    import xosera_pkg::*;

    reg_num_e           reg_num;
    logic               wr_acc;                   // sampled write access
    logic               rd_acc;                   // sampled read access
    logic [7:0]         even_q;                   // latched even byte
    logic [15:0]        commit_word;              // word formed on odd write
    logic [VRAM_AW-1:0] wr_addr;
    logic [VRAM_AW-1:0] rd_addr;
    logic [15:0]        rd_word;                  // prefetched VRAM word
    logic [15:0]        rd_val;                   // word selected for reads
    ctrl_state_e        state;
    logic               pf_first;                 // VRAM read still in flight

    assign reg_num     = reg_num_e'(bus.reg_num);
    assign wr_acc      = !bus.cs_n && !bus.rd_nwr;
    assign rd_acc      = !bus.cs_n && bus.rd_nwr;
    assign commit_word = {even_q, bus.data_in};   // big-endian
    assign vram_addr_o = (state == CTRL_PREFETCH) ? rd_addr : wr_addr;   // port A share

    always_comb begin
        case (reg_num)
            REG_WR_ADDR: rd_val = 16'(wr_addr);
            REG_DATA:    rd_val = vram_wdata_o;   // last word written
            REG_RD_ADDR: rd_val = 16'(rd_addr);
            REG_RD_DATA: rd_val = rd_word;
            REG_AUDIO:   rd_val = {audio_l_o, audio_r_o};
            default:     rd_val = '0;             // unused numbers read zero
        endcase
    end

    always_ff @(posedge pclk) begin
        if (wr_acc && !bus.bytesel)
            even_q <= bus.data_in;
        if (wr_acc && bus.bytesel && reg_num == REG_DATA)
            vram_wdata_o <= commit_word;
        if (state == CTRL_PREFETCH && !pf_first)
            rd_word <= vram_rdata_i;              // second cycle, data valid
    end

    always_ff @(posedge pclk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_addr      <= '0;
            rd_addr      <= '0;
            audio_l_o    <= '0;
            audio_r_o    <= '0;
            vram_we_o    <= 1'b0;
            state        <= CTRL_IDLE;
            pf_first     <= 1'b0;
            bus.data_out <= '0;
            bus.out_ena  <= 1'b0;
        end else begin
            vram_we_o <= 1'b0;                    // one cycle pulse
            if (vram_we_o)
                wr_addr <= wr_addr + 1'b1;        // bump with the write
            if (state == CTRL_PREFETCH) begin
                pf_first <= 1'b0;
                if (!pf_first)
                    state <= CTRL_IDLE;
            end
            if (bus.cs_n)
                bus.out_ena <= 1'b0;
            if (wr_acc && bus.bytesel) begin      // odd byte commits
                case (reg_num)
                    REG_WR_ADDR: wr_addr <= commit_word[VRAM_AW-1:0];
                    REG_DATA:    vram_we_o <= 1'b1;
                    REG_RD_ADDR: begin
                        rd_addr  <= commit_word[VRAM_AW-1:0];
                        state    <= CTRL_PREFETCH;
                        pf_first <= 1'b1;
                    end
                    REG_AUDIO: begin
                        audio_l_o <= even_q;
                        audio_r_o <= bus.data_in;
                    end
                    default: ;                    // writes ignored
                endcase
            end
            if (rd_acc) begin
                bus.data_out <= bus.bytesel ? rd_val[7:0] : rd_val[15:8];
                bus.out_ena  <= 1'b1;
                if (bus.bytesel && reg_num == REG_RD_DATA) begin
                    rd_addr  <= rd_addr + 1'b1;   // next word
                    state    <= CTRL_PREFETCH;
                    pf_first <= 1'b1;
                end
            end
        end
    end

    a_we_no_prefetch: assert property (@(posedge pclk) disable iff (!rst_n_i)
        !(vram_we_o && state == CTRL_PREFETCH));
    a_we_single: assert property (@(posedge pclk) disable iff (!rst_n_i)
        vram_we_o |=> !vram_we_o);

endmodule

//--- source/xosera_if.sv
// ##################################################
// host bus and video timing bundles
// bus signals are plain sampled levels, no handshake
// ##################################################

interface host_bus_if;
    logic       cs_n;                             // select, active low
    logic       rd_nwr;                           // 1 read, 0 write
    logic       bytesel;                          // 0 even (high) byte, 1 odd
    logic [3:0] reg_num;                          // 16-bit register number
    logic [7:0] data_in;                          // host to controller
    logic [7:0] data_out;                         // controller to host
    logic       out_ena;                          // drive data bus

    modport ctrl (
        input  cs_n, rd_nwr, bytesel, reg_num, data_in,
        output data_out, out_ena
    );
endinterface

interface vid_if;
    import xosera_pkg::*;

    logic [H_CW-1:0] h_count;                     // pixel within line
    logic [V_CW-1:0] v_count;                     // line within frame
    logic            de;                          // visible area
    logic            hsync;                       // active high
    logic            vsync;                       // active high

    modport source (output h_count, v_count, de, hsync, vsync);
    modport sink   (input  h_count, v_count, de, hsync, vsync);
endinterface

//--- source/xosera_pkg.sv
// ##################################################
// shared constants and enums of the controller
// video timings are tiny, for fast simulation only
// one VRAM word per visible pixel, no scrolling
// ##################################################

package xosera_pkg;

    // horizontal line in pixels
    localparam int H_ACTIVE = 16;
    localparam int H_FRONT  = 2;
    localparam int H_SYNC   = 4;
    localparam int H_BACK   = 2;
    localparam int H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;   // 24

    // vertical frame in lines
    localparam int V_ACTIVE = 8;
    localparam int V_FRONT  = 1;
    localparam int V_SYNC   = 2;
    localparam int V_BACK   = 1;
    localparam int V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;   // 12

    localparam int H_CW = $clog2(H_TOTAL);        // pixel counter width
    localparam int V_CW = $clog2(V_TOTAL);        // line counter width

    localparam int VRAM_WORDS = 128;              // H_ACTIVE * V_ACTIVE
    localparam int VRAM_AW    = 7;                // VRAM word address width

    localparam int AUDIO_W = 8;                   // level and PWM counter width

    typedef enum logic [3:0] {
        REG_WR_ADDR = 4'd0,                       // VRAM write address
        REG_DATA    = 4'd1,                       // write data, bumps write addr
        REG_RD_ADDR = 4'd2,                       // VRAM read address
        REG_RD_DATA = 4'd3,                       // prefetched word, read only
        REG_AUDIO   = 4'd4                        // left level high, right low
    } reg_num_e;

    typedef enum logic {
        CTRL_IDLE,
        CTRL_PREFETCH                             // VRAM read in progress
    } ctrl_state_e;

endpackage
